// ==== build.f ====
+incdir+include
design/rv32i_types.sv
design/control_rom.sv
design/imm_gen.sv
design/regfile.sv
design/alu_cmp.sv
design/rv32i_exec_core.sv
tb/rv32i_exec_core_assert.sv
tb/tb_rv32i_exec_core.sv

// ==== design/alu_cmp.sv ====
`timescale 1ns/1ps

module alu_cmp import rv32i_types::*; (
    input  alu_ops         aluop,
    input  branch_funct3_t cmpop,
    input  rv32i_word      a,
    input  rv32i_word      b,
    input  rv32i_word      cmp_a,
    input  rv32i_word      cmp_b,
    output rv32i_word      alu_out,
    output logic           br_en
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            alu_add: alu_out = a + b;
            alu_sll: alu_out = a << shamt;
            alu_sra: alu_out = rv32i_word'($signed(a) >>> shamt);
            alu_sub: alu_out = a - b;
            alu_xor: alu_out = a ^ b;
            alu_srl: alu_out = a >> shamt;
            alu_or:  alu_out = a | b;
            alu_and: alu_out = a & b;
        endcase
    end

    assign eq   = (cmp_a == cmp_b);
    assign lt_s = ($signed(cmp_a) < $signed(cmp_b));
    assign lt_u = (cmp_a < cmp_b);

    // also serves slt and sltu through blt and bltu.
    always_comb begin
        case (cmpop)
            beq:     br_en = eq;
            bne:     br_en = !eq;
            blt:     br_en = lt_s;
            bge:     br_en = !lt_s;
            bltu:    br_en = lt_u;
            bgeu:    br_en = !lt_u;
            default: br_en = 1'b0;
        endcase
    end

endmodule

// ==== design/control_rom.sv ====
`timescale 1ns/1ps

module control_rom import rv32i_types::*; (
    input  rv32i_word      ir,
    output imm_sel_t       imm_sel,
    output alu_ops         aluop,
    output branch_funct3_t cmpop,
    output alumux1_sel_t   alumux1_sel,
    output alumux2_sel_t   alumux2_sel,
    output logic           cmpmux_sel,
    output wbmux_sel_t     wbmux_sel,
    output pcmux_sel_t     pcmux_sel,
    output rv32i_reg       rs1,
    output rv32i_reg       rs2,
    output rv32i_reg       rd,
    output logic           load_regfile,
    output logic           dmem_read,
    output logic           dmem_write,
    output logic           illegal
);

    rv32i_opcode   opcode;
    arith_funct3_t arith_f3;
    logic [2:0]    funct3;
    logic          alt_op;
    rv32i_reg      ir_rs1;
    rv32i_reg      ir_rs2;
    rv32i_reg      ir_rd;

    assign opcode   = rv32i_opcode'(ir[6:0]);
    assign funct3   = ir[14:12];
    assign arith_f3 = arith_funct3_t'(funct3);
    // funct7 bit 5 picks sub and sra.
    assign alt_op   = ir[30];
    assign ir_rs1   = ir[19:15];
    assign ir_rs2   = ir[24:20];
    assign ir_rd    = ir[11:7];

    always_comb begin
        imm_sel      = i_imm_sel;
        aluop        = alu_ops'(funct3);
        cmpop        = branch_funct3_t'(funct3);
        alumux1_sel  = rs1_sel;
        alumux2_sel  = rv32i_types::imm_sel;
        cmpmux_sel   = 1'b0;
        wbmux_sel    = alu_out_wb_sel;
        pcmux_sel    = pc_plus4;
        rs1          = '0;
        rs2          = '0;
        rd           = '0;
        load_regfile = 1'b0;
        dmem_read    = 1'b0;
        dmem_write   = 1'b0;
        illegal      = 1'b0;

        case (opcode)
            op_lui: begin
                load_regfile = 1'b1;
                imm_sel      = u_imm_sel;
                wbmux_sel    = imm_wb_sel;
                rd           = ir_rd;
            end
            op_auipc: begin
                load_regfile = 1'b1;
                imm_sel      = u_imm_sel;
                aluop        = alu_add;
                alumux1_sel  = pc_out_sel;
                rd           = ir_rd;
            end
            op_jal: begin
                load_regfile = 1'b1;
                imm_sel      = j_imm_sel;
                aluop        = alu_add;
                alumux1_sel  = pc_out_sel;
                wbmux_sel    = pc_inc_wb_sel;
                pcmux_sel    = pc_alu_out;
                rd           = ir_rd;
            end
            op_jalr: begin
                load_regfile = 1'b1;
                aluop        = alu_add;
                wbmux_sel    = pc_inc_wb_sel;
                pcmux_sel    = pc_alu_out;
                rs1          = ir_rs1;
                rd           = ir_rd;
            end
            op_br: begin
                // the ALU forms the target while the comparator decides.
                imm_sel     = b_imm_sel;
                aluop       = alu_add;
                alumux1_sel = pc_out_sel;
                pcmux_sel   = pc_branch;
                rs1         = ir_rs1;
                rs2         = ir_rs2;
            end
            op_load: begin
                load_regfile = 1'b1;
                aluop        = alu_add;
                dmem_read    = 1'b1;
                wbmux_sel    = rdata_wb_sel;
                rs1          = ir_rs1;
                rd           = ir_rd;
            end
            op_store: begin
                imm_sel    = s_imm_sel;
                aluop      = alu_add;
                dmem_write = 1'b1;
                rs1        = ir_rs1;
                rs2        = ir_rs2;
            end
            op_imm: begin
                load_regfile = 1'b1;
                rs1          = ir_rs1;
                rd           = ir_rd;
                if (arith_f3 == slt || arith_f3 == sltu) begin
                    cmpop      = (arith_f3 == slt) ? blt : bltu;
                    cmpmux_sel = 1'b1;
                    wbmux_sel  = br_en_wb_sel;
                end else if (arith_f3 == sr && alt_op) begin
                    aluop = alu_sra;
                end
            end
            op_reg: begin
                load_regfile = 1'b1;
                alumux2_sel  = rs2_sel;
                rs1          = ir_rs1;
                rs2          = ir_rs2;
                rd           = ir_rd;
                if (arith_f3 == slt || arith_f3 == sltu) begin
                    cmpop     = (arith_f3 == slt) ? blt : bltu;
                    wbmux_sel = br_en_wb_sel;
                end else if (arith_f3 == sr && alt_op) begin
                    aluop = alu_sra;
                end else if (arith_f3 == add && alt_op) begin
                    aluop = alu_sub;
                end
            end
            default: begin
                // runs as a no-op, all strobes stay at their defaults.
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== design/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen import rv32i_types::*; (
    input  rv32i_word ir,
    input  imm_sel_t  imm_sel,
    output rv32i_word imm
);

    rv32i_word i_imm;
    rv32i_word s_imm;
    rv32i_word b_imm;
    rv32i_word u_imm;
    rv32i_word j_imm;

    // every form takes its sign from bit 31.
    assign i_imm = {{21{ir[31]}}, ir[30:20]};
    assign s_imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
    assign b_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign u_imm = {ir[31:12], 12'h000};
    assign j_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        case (imm_sel)
            s_imm_sel: imm = s_imm;
            b_imm_sel: imm = b_imm;
            u_imm_sel: imm = u_imm;
            j_imm_sel: imm = j_imm;
            default:   imm = i_imm;
        endcase
    end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module regfile import rv32i_types::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      load,
    input  rv32i_reg  rd,
    input  rv32i_word wdata,
    input  rv32i_reg  rs1,
    input  rv32i_reg  rs2,
    output rv32i_word rs1_data,
    output rv32i_word rs2_data
);

    // x0 has no storage.
    rv32i_word regs [1:`RV_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/rv32i_exec_core.sv ====
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module rv32i_exec_core import rv32i_types::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  rv32i_word ir,
    input  rv32i_word dmem_rdata,
    output rv32i_word pc,
    output logic      dmem_read,
    output logic      dmem_write,
    output rv32i_word dmem_addr,
    output rv32i_word dmem_wdata,
    output logic      wb_en,
    output rv32i_reg  wb_rd,
    output rv32i_word wb_data,
    output logic      illegal_instr
);

    imm_sel_t       imm_sel;
    alu_ops         aluop;
    branch_funct3_t cmpop;
    alumux1_sel_t   alumux1_sel;
    alumux2_sel_t   alumux2_sel;
    logic           cmpmux_sel;
    wbmux_sel_t     wbmux_sel;
    pcmux_sel_t     pcmux_sel;
    rv32i_reg       rs1;
    rv32i_reg       rs2;
    rv32i_reg       rd;
    logic           load_regfile;
    logic           mem_rd;
    logic           mem_wr;
    logic           illegal;
    logic           br_en;
    logic           active;
    rv32i_word      imm;
    rv32i_word      rs1_data;
    rv32i_word      rs2_data;
    rv32i_word      alu_a;
    rv32i_word      alu_b;
    rv32i_word      cmp_b;
    rv32i_word      alu_out;
    rv32i_word      pc_plus_4;
    rv32i_word      wb_mux;
    rv32i_word      next_pc;

    control_rom u_control_rom (
        .ir           (ir),
        .imm_sel      (imm_sel),
        .aluop        (aluop),
        .cmpop        (cmpop),
        .alumux1_sel  (alumux1_sel),
        .alumux2_sel  (alumux2_sel),
        .cmpmux_sel   (cmpmux_sel),
        .wbmux_sel    (wbmux_sel),
        .pcmux_sel    (pcmux_sel),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .load_regfile (load_regfile),
        .dmem_read    (mem_rd),
        .dmem_write   (mem_wr),
        .illegal      (illegal)
    );

    imm_gen u_imm_gen (
        .ir      (ir),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .load     (wb_en),
        .rd       (wb_rd),
        .wdata    (wb_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_a = (alumux1_sel == pc_out_sel) ? pc : rs1_data;
    assign alu_b = (alumux2_sel == rs2_sel) ? rs2_data : imm;
    // slti and sltiu compare against the immediate.
    assign cmp_b = cmpmux_sel ? imm : rs2_data;

    alu_cmp u_alu_cmp (
        .aluop   (aluop),
        .cmpop   (cmpop),
        .a       (alu_a),
        .b       (alu_b),
        .cmp_a   (rs1_data),
        .cmp_b   (cmp_b),
        .alu_out (alu_out),
        .br_en   (br_en)
    );

    assign pc_plus_4 = pc + 32'd4;

    always_comb begin
        case (wbmux_sel)
            br_en_wb_sel:  wb_mux = {{(`RV_XLEN-1){1'b0}}, br_en};
            imm_wb_sel:    wb_mux = imm;
            rdata_wb_sel:  wb_mux = dmem_rdata;
            pc_inc_wb_sel: wb_mux = pc_plus_4;
            default:       wb_mux = alu_out;
        endcase
    end

    always_comb begin
        case (pcmux_sel)
            pc_alu_out: next_pc = {alu_out[`RV_XLEN-1:1], 1'b0};
            pc_branch:  next_pc = br_en ? alu_out : pc_plus_4;
            default:    next_pc = pc_plus_4;
        endcase
    end

    // an instruction only counts when it is valid and the core is out of reset.
    assign active        = instr_valid & ~reset;
    assign dmem_read     = active & mem_rd;
    assign dmem_write    = active & mem_wr;
    assign dmem_addr     = active ? alu_out : '0;
    assign dmem_wdata    = rs2_data;
    assign wb_en         = active & load_regfile & (rd != '0);
    assign wb_rd         = active ? rd : '0;
    assign wb_data       = active ? wb_mux : '0;
    assign illegal_instr = active & illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (instr_valid) begin
            pc <= next_pc;
        end
    end

endmodule

// ==== design/rv32i_types.sv ====
`include "rv32i_settings.svh"

package rv32i_types;

    typedef logic [`RV_XLEN-1:0] rv32i_word;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // sub and sra sit in the funct3 slots of slt and sltu, which never reach the ALU.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        i_imm_sel,
        s_imm_sel,
        b_imm_sel,
        u_imm_sel,
        j_imm_sel
    } imm_sel_t;

    typedef enum logic [2:0] {
        alu_out_wb_sel,
        br_en_wb_sel,
        imm_wb_sel,
        rdata_wb_sel,
        pc_inc_wb_sel
    } wbmux_sel_t;

    typedef enum logic {
        rs1_sel,
        pc_out_sel
    } alumux1_sel_t;

    typedef enum logic {
        imm_sel,
        rs2_sel
    } alumux2_sel_t;

    typedef enum logic [1:0] {
        pc_plus4,
        pc_alu_out,
        pc_branch
    } pcmux_sel_t;

endpackage

// ==== include/rv32i_settings.svh ====
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// data, address and instruction width.
`define RV_XLEN 32

// architectural register count, x0 included.
`define RV_NUM_REGS 32

// fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is the simulator's, so a failed run returns nonzero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_rv32i_exec_core \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_rv32i_exec_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// ==== tb/rv32i_exec_core_assert.sv ====
`timescale 1ns/1ps

module rv32i_exec_core_assert import rv32i_types::*; (
    input logic      clk,
    input logic      reset,
    input logic      instr_valid,
    input logic      dmem_read,
    input logic      dmem_write,
    input logic      wb_en,
    input logic      illegal_instr,
    input rv32i_reg  wb_rd,
    input rv32i_word pc
);

    a_mem_exclusive: assert property (@(posedge clk) !(dmem_read && dmem_write))
        else $error("dmem_read and dmem_write are high together");

    a_wb_rd_nonzero: assert property (@(posedge clk) wb_en |-> (wb_rd != '0))
        else $error("wb_en is set with x0 as destination");

    // an idle or held cycle must leave every strobe low.
    a_idle_quiet: assert property (@(posedge clk)
        (reset || !instr_valid) |-> !(dmem_read || dmem_write || wb_en || illegal_instr))
        else $error("a strobe is high while in reset or with instr_valid low");

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

bind rv32i_exec_core rv32i_exec_core_assert u_assert (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .dmem_read     (dmem_read),
    .dmem_write    (dmem_write),
    .wb_en         (wb_en),
    .illegal_instr (illegal_instr),
    .wb_rd         (wb_rd),
    .pc            (pc)
);

// ==== tb/tb_rv32i_exec_core.sv ====
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module tb_rv32i_exec_core;

    localparam int PERIOD_NS = 40;
    localparam int NUM_CYCLES = 3000;
    localparam int RESET_CYCLES = 2;
    localparam int TIMEOUT_NS = (NUM_CYCLES + RESET_CYCLES + 20) * PERIOD_NS;
    localparam logic [15:0] SEED = 16'd42810;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] ir;
    logic [31:0] dmem_rdata;
    logic [31:0] pc;
    logic        dmem_read;
    logic        dmem_write;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        illegal_instr;

    logic [15:0] lfsr;
    logic [31:0] mregs [0:31];
    logic [31:0] mpc;

    rv32i_exec_core u_dut (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .ir            (ir),
        .dmem_rdata    (dmem_rdata),
        .pc            (pc),
        .dmem_read     (dmem_read),
        .dmem_write    (dmem_write),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .illegal_instr (illegal_instr)
    );

    // data memory answers in the same cycle with a fixed pattern of the address.
    assign dmem_rdata = mem_word(dmem_addr);

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'hA5C3_96E1;
        return {x[24:0], x[31:25]};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic alt,
                                                 input logic is_imm, input logic [31:0] x,
                                                 input logic [31:0] y);
        case (f3)
            3'b000: return (alt && !is_imm) ? x - y : x + y;
            3'b001: return x << y[4:0];
            3'b010: return {31'b0, $signed(x) < $signed(y)};
            3'b011: return {31'b0, x < y};
            3'b100: return x ^ y;
            3'b101: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                          input logic [31:0] y);
        case (f3)
            3'b000: return x == y;
            3'b001: return x != y;
            3'b100: return $signed(x) < $signed(y);
            3'b101: return $signed(x) >= $signed(y);
            3'b110: return x < y;
            3'b111: return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL @ %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // builds one instruction from the legal subset, with a few unknown opcodes.
    task automatic make_instr(output logic valid, output logic [31:0] instr);
        logic [31:0] r;
        logic [31:0] bits;
        logic [3:0]  c;
        take_bits(3, r);
        valid = (r[2:0] != 3'b000);
        take_bits(32, bits);
        take_bits(4, r);
        c = r[3:0];
        instr = bits;
        case (c)
            4'd0, 4'd1: instr[6:0] = 7'b0110111;
            4'd2: instr[6:0] = 7'b0010111;
            4'd3, 4'd4: begin
                instr[6:0] = 7'b1101111;
                instr[21] = 1'b0;
            end
            4'd5: begin
                // the low offset bits cancel those of the base so the target stays aligned.
                instr[6:0] = 7'b1100111;
                instr[14:12] = 3'b000;
                instr[21:20] = 2'b00 - mregs[instr[19:15]][1:0];
            end
            4'd6, 4'd7: begin
                instr[6:0] = 7'b1100011;
                instr[8] = 1'b0;
                if (instr[14:13] == 2'b01) begin
                    instr[13] = 1'b0;
                end
            end
            4'd8: begin
                instr[6:0] = 7'b0000011;
                instr[14:12] = 3'b010;
            end
            4'd9: begin
                instr[6:0] = 7'b0100011;
                instr[14:12] = 3'b010;
            end
            4'd10, 4'd11, 4'd12: begin
                instr[6:0] = 7'b0010011;
                if (instr[14:12] == 3'b001) begin
                    instr[31:25] = 7'b0;
                end else if (instr[14:12] == 3'b101) begin
                    instr[31:25] = {1'b0, instr[30], 5'b0};
                end
            end
            4'd13, 4'd14: begin
                instr[6:0] = 7'b0110011;
                if (instr[14:12] == 3'b000 || instr[14:12] == 3'b101) begin
                    instr[31:25] = {1'b0, instr[30], 5'b0};
                end else begin
                    instr[31:25] = 7'b0;
                end
            end
            default: begin
                take_bits(2, r);
                case (r[1:0])
                    2'd0: instr[6:0] = 7'b0001111;
                    2'd1: instr[6:0] = 7'b1110011;
                    2'd2: instr[6:0] = 7'b0000000;
                    default: instr[6:0] = 7'b1111111;
                endcase
            end
        endcase
    endtask

    // runs the current instruction on the model and compares the DUT outputs.
    task automatic check_cycle();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] exp_wb;
        logic [31:0] exp_addr;
        logic [31:0] next;
        logic        exp_we;
        logic        exp_rd;
        logic        exp_wr;
        logic        exp_ill;
        logic [4:0]  rd;
        a = mregs[ir[19:15]];
        b = mregs[ir[24:20]];
        rd = ir[11:7];
        imm_i = {{20{ir[31]}}, ir[31:20]};
        imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
        imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
        imm_u = {ir[31:12], 12'b0};
        imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
        exp_wb = '0;
        exp_addr = '0;
        next = mpc + 32'd4;
        exp_we = 1'b0;
        exp_rd = 1'b0;
        exp_wr = 1'b0;
        exp_ill = 1'b0;
        check_value(pc, mpc, "pc");
        if (!instr_valid) begin
            check_value(32'(dmem_read), 32'd0, "dmem_read while idle");
            check_value(32'(dmem_write), 32'd0, "dmem_write while idle");
            check_value(32'(wb_en), 32'd0, "wb_en while idle");
            check_value(32'(illegal_instr), 32'd0, "illegal_instr while idle");
        end else begin
            case (ir[6:0])
                7'b0110111: begin
                    exp_we = 1'b1;
                    exp_wb = imm_u;
                end
                7'b0010111: begin
                    exp_we = 1'b1;
                    exp_wb = mpc + imm_u;
                end
                7'b1101111: begin
                    exp_we = 1'b1;
                    exp_wb = mpc + 32'd4;
                    next = mpc + imm_j;
                end
                7'b1100111: begin
                    exp_we = 1'b1;
                    exp_wb = mpc + 32'd4;
                    next = (a + imm_i) & ~32'd1;
                end
                7'b1100011: begin
                    if (branch_taken(ir[14:12], a, b)) begin
                        next = mpc + imm_b;
                    end
                end
                7'b0000011: begin
                    exp_rd = 1'b1;
                    exp_we = 1'b1;
                    exp_addr = a + imm_i;
                    exp_wb = mem_word(exp_addr);
                end
                7'b0100011: begin
                    exp_wr = 1'b1;
                    exp_addr = a + imm_s;
                end
                7'b0010011: begin
                    exp_we = 1'b1;
                    exp_wb = arith_result(ir[14:12], ir[30], 1'b1, a, imm_i);
                end
                7'b0110011: begin
                    exp_we = 1'b1;
                    exp_wb = arith_result(ir[14:12], ir[30], 1'b0, a, b);
                end
                default: exp_ill = 1'b1;
            endcase
            if (rd == 5'd0) begin
                exp_we = 1'b0;
            end
            check_value(32'(illegal_instr), 32'(exp_ill), "illegal_instr");
            check_value(32'(dmem_read), 32'(exp_rd), "dmem_read");
            check_value(32'(dmem_write), 32'(exp_wr), "dmem_write");
            check_value(32'(wb_en), 32'(exp_we), "wb_en");
            if (exp_we) begin
                check_value(32'(wb_rd), 32'(rd), "wb_rd");
                check_value(wb_data, exp_wb, "wb_data");
                mregs[rd] = exp_wb;
            end
            if (exp_rd || exp_wr) begin
                check_value(dmem_addr, exp_addr, "dmem_addr");
            end
            if (exp_wr) begin
                check_value(dmem_wdata, b, "dmem_wdata");
            end
            mpc = next;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all cycles were checked");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] instr;
        logic        valid;
        reset = 1'b1;
        instr_valid = 1'b1;
        // lw x1, 8(x2) is offered in the first reset cycle and must stay blocked.
        ir = 32'h0081_2083;
        lfsr = SEED;
        mpc = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        #(PERIOD_NS / 4);
        check_value(32'(dmem_read), 32'd0, "dmem_read in reset");
        check_value(32'(wb_en), 32'd0, "wb_en in reset");
        @(posedge clk);
        #1;
        // sw x10, 8(x2) follows in the second reset cycle.
        ir = 32'h00A1_2423;
        @(negedge clk);
        check_value(32'(dmem_write), 32'd0, "dmem_write in reset");
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value(pc, `RV_RESET_PC, "pc after reset");
        for (int n = 0; n < NUM_CYCLES; n++) begin
            make_instr(valid, instr);
            instr_valid = valid;
            ir = instr;
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            #1;
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule
